// ==== hw/ln_pkg.sv ====
// Layer norm constants; FEATURE_DIM must be a power of two so that RECIP_N is exact
`default_nettype none

package ln_pkg;

    localparam int FEATURE_DIM = 16;             // Elements per vector
    localparam int ADDR_W      = $clog2(FEATURE_DIM);
    localparam int IDX_W       = $clog2(FEATURE_DIM + 1);

    // Q8.8 data and affine parameters
    localparam int DATA_W    = 16;
    localparam int PARAM_W   = 16;
    localparam int FRAC_BITS = 8;

    localparam int SUM_W    = 32;
    localparam int SUM_SQ_W = 48;                // Also the variance word
    localparam int SQ_W     = 2 * DATA_W;

    // Norm factor is unsigned Q1.16 in a signed word
    localparam int NF_FRAC = 16;
    localparam int NF_W    = 18;

    localparam int RECIP_SHIFT = 16;
    localparam int RECIP_N     = (1 << RECIP_SHIFT) / FEATURE_DIM;
    localparam int EPSILON     = 1;              // Q16 units of the variance

    localparam int ISQRT_STEPS     = NF_W - 1;   // One result bit per cycle
    localparam int ISQRT_ONE_SHIFT = 2 * NF_FRAC + 2 * FRAC_BITS;
    localparam int ISQRT_TEST_W    = 2 * ISQRT_STEPS + SUM_SQ_W - 1;
    localparam logic [ISQRT_TEST_W-1:0] ISQRT_LIMIT = {
        {(ISQRT_TEST_W - ISQRT_ONE_SHIFT - 1){1'b0}}, 1'b1, {ISQRT_ONE_SHIFT{1'b0}}
    };

    localparam int STAT_DEPTH = 2;
    localparam int MV_LATENCY = 2;               // Mean, then variance
    localparam int NORM_DEPTH = 4;

    // Normalize datapath widths
    localparam int CENT_W    = DATA_W + 1;
    localparam int PROD_W    = CENT_W + NF_W;
    localparam int SCALED_W  = PROD_W + PARAM_W;
    localparam int OUT_SHIFT = NF_FRAC + 2 * FRAC_BITS;

endpackage

`default_nettype wire

// ==== hw/ln_control.sv ====
// Run sequencer; starts only on a rising i_start edge while idle, edges during a run are dropped
`default_nettype none

module ln_control (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      i_start,
    input  wire                      i_isqrt_done,
    output logic                     o_stat_clear,
    output logic                     o_stat_rd,
    output logic                     o_mv_start,
    output logic                     o_isqrt_start,
    output logic                     o_norm_clear,
    output logic                     o_norm_rd,
    output logic [ln_pkg::IDX_W-1:0] o_rd_idx,
    output logic                     o_busy,
    output logic                     o_done
);

    enum logic [3:0] {
        S_IDLE,
        S_STAT_CLEAR,
        S_STAT_RD,
        S_STAT_DRAIN,
        S_MV_START,
        S_MV_WAIT,
        S_ISQRT_START,
        S_ISQRT_WAIT,
        S_NORM_CLEAR,
        S_NORM_RD,
        S_NORM_DRAIN,
        S_DONE
    } state, state_nxt;

    logic                     start_q;
    logic                     start_edge;
    logic [ln_pkg::IDX_W-1:0] idx_cnt;
    logic [ln_pkg::IDX_W-1:0] drain_cnt;
    logic                     last_idx;

    assign start_edge = i_start && !start_q;
    assign last_idx   = (idx_cnt == ln_pkg::IDX_W'(ln_pkg::FEATURE_DIM - 1));

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:        if (start_edge) state_nxt = S_STAT_CLEAR;
            S_STAT_CLEAR:  state_nxt = S_STAT_RD;
            S_STAT_RD:     if (last_idx) state_nxt = S_STAT_DRAIN;
            S_STAT_DRAIN: begin
                if (drain_cnt == ln_pkg::IDX_W'(ln_pkg::STAT_DEPTH - 1)) state_nxt = S_MV_START;
            end
            S_MV_START:    state_nxt = S_MV_WAIT;
            S_MV_WAIT: begin
                if (drain_cnt == ln_pkg::IDX_W'(ln_pkg::MV_LATENCY - 1)) state_nxt = S_ISQRT_START;
            end
            S_ISQRT_START: state_nxt = S_ISQRT_WAIT;
            S_ISQRT_WAIT:  if (i_isqrt_done) state_nxt = S_NORM_CLEAR;
            S_NORM_CLEAR:  state_nxt = S_NORM_RD;
            S_NORM_RD:     if (last_idx) state_nxt = S_NORM_DRAIN;
            S_NORM_DRAIN: begin
                if (drain_cnt == ln_pkg::IDX_W'(ln_pkg::NORM_DEPTH - 1)) state_nxt = S_DONE;
            end
            S_DONE:        state_nxt = S_IDLE;
            default:       state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            start_q   <= 1'b0;
            idx_cnt   <= '0;
            drain_cnt <= '0;
        end else begin
            state   <= state_nxt;
            start_q <= i_start;
            if (state_nxt != state) begin   // Counters restart on every state change
                idx_cnt   <= '0;
                drain_cnt <= '0;
            end else begin
                if (state == S_STAT_RD || state == S_NORM_RD) idx_cnt <= idx_cnt + 1'b1;
                if (state == S_STAT_DRAIN || state == S_MV_WAIT || state == S_NORM_DRAIN) begin
                    drain_cnt <= drain_cnt + 1'b1;
                end
            end
        end
    end

    assign o_stat_clear  = (state == S_STAT_CLEAR);
    assign o_stat_rd     = (state == S_STAT_RD);
    assign o_mv_start    = (state == S_MV_START);
    assign o_isqrt_start = (state == S_ISQRT_START);
    assign o_norm_clear  = (state == S_NORM_CLEAR);
    assign o_norm_rd     = (state == S_NORM_RD);
    assign o_rd_idx      = idx_cnt;
    assign o_busy        = (state != S_IDLE) && (state != S_DONE);
    assign o_done        = (state == S_DONE);

endmodule

`default_nettype wire

// ==== hw/ln_stats_accum.sv ====
// Statistics pass; sums become final two cycles after the last read, i_clear must precede a pass
`default_nettype none

module ln_stats_accum (
    input  wire                                     clk,
    input  wire                                     rst_n,
    input  wire                                     i_clear,
    input  wire                                     i_rd,
    input  wire        [ln_pkg::IDX_W-1:0]          i_rd_idx,
    input  wire signed [ln_pkg::DATA_W-1:0]         i_x [ln_pkg::FEATURE_DIM],
    output logic signed [ln_pkg::SUM_W-1:0]         o_sum,
    output logic signed [ln_pkg::SUM_SQ_W-1:0]      o_sum_sq
);

    logic signed [ln_pkg::DATA_W-1:0] x_s0;
    logic signed [ln_pkg::DATA_W-1:0] x_s1;
    logic signed [ln_pkg::SQ_W-1:0]   sq_s1;
    logic                             v_s0;
    logic                             v_s1;

    // Fetch and square, payload only
    always_ff @(posedge clk) begin
        if (i_rd) x_s0 <= i_x[i_rd_idx[ln_pkg::ADDR_W-1:0]];
        x_s1  <= x_s0;
        sq_s1 <= x_s0 * x_s0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v_s0     <= 1'b0;
            v_s1     <= 1'b0;
            o_sum    <= '0;
            o_sum_sq <= '0;
        end else if (i_clear) begin
            v_s0     <= 1'b0;
            v_s1     <= 1'b0;
            o_sum    <= '0;
            o_sum_sq <= '0;
        end else begin
            v_s0 <= i_rd;
            v_s1 <= v_s0;
            if (v_s1) begin
                o_sum    <= o_sum + x_s1;       // Sign-extended to the accumulator
                o_sum_sq <= o_sum_sq + sq_s1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/ln_mean_var.sv ====
// Mean then variance plus epsilon, one cycle each after i_start; sums must be stable meanwhile
`default_nettype none

module ln_mean_var (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  i_start,
    input  wire signed [ln_pkg::SUM_W-1:0]       i_sum,
    input  wire signed [ln_pkg::SUM_SQ_W-1:0]    i_sum_sq,
    output logic signed [ln_pkg::DATA_W-1:0]     o_mean,
    output logic signed [ln_pkg::SUM_SQ_W-1:0]   o_var_eps
);

    logic signed [ln_pkg::SUM_W+ln_pkg::RECIP_SHIFT-1:0]    mean_prod;
    logic signed [ln_pkg::SUM_SQ_W+ln_pkg::RECIP_SHIFT-1:0] sq_prod;
    logic signed [ln_pkg::SUM_SQ_W-1:0]                     mean_sq_avg;
    logic signed [2*ln_pkg::DATA_W-1:0]                     mean_sq;
    logic                                                   var_pend;

    // Divide by N as a Q16 reciprocal multiply
    assign mean_prod   = i_sum * ln_pkg::RECIP_N;
    assign sq_prod     = i_sum_sq * ln_pkg::RECIP_N;
    assign mean_sq_avg = sq_prod[ln_pkg::RECIP_SHIFT +: ln_pkg::SUM_SQ_W];
    assign mean_sq     = o_mean * o_mean;    // Registered mean from the previous cycle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            var_pend <= 1'b0;
        end else begin
            var_pend <= i_start;
        end
    end

    always_ff @(posedge clk) begin
        if (i_start) o_mean <= mean_prod[ln_pkg::RECIP_SHIFT +: ln_pkg::DATA_W];
        if (var_pend) o_var_eps <= mean_sq_avg - mean_sq + ln_pkg::EPSILON;
    end

endmodule

`default_nettype wire

// ==== hw/ln_inv_sqrt.sv ====
// Inverse square root in 17 cycles after i_start; i_var_eps must stay stable until o_done
`default_nettype none

module ln_inv_sqrt (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 i_start,
    input  wire signed [ln_pkg::SUM_SQ_W-1:0]   i_var_eps,
    output logic signed [ln_pkg::NF_W-1:0]      o_norm_factor,
    output logic                                o_done
);

    logic [ln_pkg::ISQRT_STEPS-1:0]    root;
    logic [ln_pkg::ISQRT_STEPS-1:0]    bit_mask;    // One-hot bit pointer, zero when idle
    logic [ln_pkg::ISQRT_STEPS-1:0]    trial;
    logic [2*ln_pkg::ISQRT_STEPS-1:0]  trial_sq;
    logic [ln_pkg::ISQRT_TEST_W-1:0]   trial_test;
    logic                              var_neg;
    logic                              keep;

    assign trial      = root | bit_mask;
    assign trial_sq   = trial * trial;
    assign trial_test = trial_sq * i_var_eps[ln_pkg::SUM_SQ_W-2:0];
    assign var_neg    = i_var_eps[ln_pkg::SUM_SQ_W-1];

    // Keep the bit while trial^2 * v stays at or below one in Q48
    assign keep = var_neg || (trial_test <= ln_pkg::ISQRT_LIMIT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            root     <= '0;
            bit_mask <= '0;
            o_done   <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                root     <= '0;
                bit_mask <= {1'b1, {(ln_pkg::ISQRT_STEPS - 1){1'b0}}};
            end else if (bit_mask != '0) begin
                if (keep) root <= trial;
                bit_mask <= bit_mask >> 1;
                o_done   <= bit_mask[0];           // Last bit decided
            end
        end
    end

    assign o_norm_factor = $signed({1'b0, root});

endmodule

`default_nettype wire

// ==== hw/ln_norm_pipe.sv ====
// Normalize pass; mean and norm factor must hold during the pass, the 16-bit output wraps
`default_nettype none

module ln_norm_pipe (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 i_clear,
    input  wire                                 i_rd,
    input  wire        [ln_pkg::IDX_W-1:0]      i_rd_idx,
    input  wire signed [ln_pkg::DATA_W-1:0]     i_x     [ln_pkg::FEATURE_DIM],
    input  wire signed [ln_pkg::PARAM_W-1:0]    i_gamma [ln_pkg::FEATURE_DIM],
    input  wire signed [ln_pkg::PARAM_W-1:0]    i_beta  [ln_pkg::FEATURE_DIM],
    input  wire signed [ln_pkg::DATA_W-1:0]     i_mean,
    input  wire signed [ln_pkg::NF_W-1:0]       i_norm_factor,
    output logic signed [ln_pkg::DATA_W-1:0]    o_y     [ln_pkg::FEATURE_DIM]
);

    logic signed [ln_pkg::DATA_W-1:0]     x_s1;
    logic signed [ln_pkg::PARAM_W-1:0]    g_s1, g_s2, g_s3;
    logic signed [ln_pkg::PARAM_W-1:0]    b_s1, b_s2, b_s3;
    logic signed [ln_pkg::CENT_W-1:0]     cent_s2;
    logic signed [ln_pkg::PROD_W-1:0]     prod_s3;
    logic signed [ln_pkg::SCALED_W-1:0]   scaled;
    logic signed [ln_pkg::SCALED_W:0]     y_sum;
    logic        [ln_pkg::IDX_W-1:0]      wr_idx;
    logic                                 v_s1, v_s2, v_s3;
    logic        [ln_pkg::ADDR_W-1:0]     rd_addr;

    assign rd_addr = i_rd_idx[ln_pkg::ADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (i_rd) begin
            x_s1 <= i_x[rd_addr];
            g_s1 <= i_gamma[rd_addr];
            b_s1 <= i_beta[rd_addr];
        end
        cent_s2 <= x_s1 - i_mean;             // 17 bits, no overflow
        g_s2    <= g_s1;
        b_s2    <= b_s1;
        prod_s3 <= cent_s2 * i_norm_factor;   // Q24 fraction
        g_s3    <= g_s2;
        b_s3    <= b_s2;
    end

    // Stage 4 is the output write itself
    assign scaled = prod_s3 * g_s3;
    assign y_sum  = scaled + (b_s3 <<< ln_pkg::OUT_SHIFT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v_s1   <= 1'b0;
            v_s2   <= 1'b0;
            v_s3   <= 1'b0;
            wr_idx <= '0;
            for (int i = 0; i < ln_pkg::FEATURE_DIM; i++) begin
                o_y[i] <= '0;
            end
        end else if (i_clear) begin
            v_s1   <= 1'b0;
            v_s2   <= 1'b0;
            v_s3   <= 1'b0;
            wr_idx <= '0;
        end else begin
            v_s1 <= i_rd;
            v_s2 <= v_s1;
            v_s3 <= v_s2;
            if (v_s3 && wr_idx < ln_pkg::IDX_W'(ln_pkg::FEATURE_DIM)) begin
                o_y[wr_idx[ln_pkg::ADDR_W-1:0]] <= y_sum[ln_pkg::OUT_SHIFT +: ln_pkg::DATA_W];
                wr_idx <= wr_idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/layer_norm_unit.sv ====
// Layer norm top; inputs must stay stable from start to done, no back-pressure
`default_nettype none

module layer_norm_unit (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 i_start,
    input  wire signed [ln_pkg::DATA_W-1:0]     i_x     [ln_pkg::FEATURE_DIM],
    input  wire signed [ln_pkg::PARAM_W-1:0]    i_gamma [ln_pkg::FEATURE_DIM],
    input  wire signed [ln_pkg::PARAM_W-1:0]    i_beta  [ln_pkg::FEATURE_DIM],
    output logic signed [ln_pkg::DATA_W-1:0]    o_y     [ln_pkg::FEATURE_DIM],
    output logic                                o_busy,
    output logic                                o_done
);

    logic                               stat_clear;
    logic                               stat_rd;
    logic                               mv_start;
    logic                               isqrt_start;
    logic                               isqrt_done;
    logic                               norm_clear;
    logic                               norm_rd;
    logic        [ln_pkg::IDX_W-1:0]    rd_idx;
    logic signed [ln_pkg::SUM_W-1:0]    sum;
    logic signed [ln_pkg::SUM_SQ_W-1:0] sum_sq;
    logic signed [ln_pkg::DATA_W-1:0]   mean;
    logic signed [ln_pkg::SUM_SQ_W-1:0] var_eps;
    logic signed [ln_pkg::NF_W-1:0]     norm_factor;

    ln_control i_control (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_start       (i_start),
        .i_isqrt_done  (isqrt_done),
        .o_stat_clear  (stat_clear),
        .o_stat_rd     (stat_rd),
        .o_mv_start    (mv_start),
        .o_isqrt_start (isqrt_start),
        .o_norm_clear  (norm_clear),
        .o_norm_rd     (norm_rd),
        .o_rd_idx      (rd_idx),
        .o_busy        (o_busy),
        .o_done        (o_done)
    );

    ln_stats_accum i_stats (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_clear  (stat_clear),
        .i_rd     (stat_rd),
        .i_rd_idx (rd_idx),
        .i_x      (i_x),
        .o_sum    (sum),
        .o_sum_sq (sum_sq)
    );

    ln_mean_var i_mean_var (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_start   (mv_start),
        .i_sum     (sum),
        .i_sum_sq  (sum_sq),
        .o_mean    (mean),
        .o_var_eps (var_eps)
    );

    ln_inv_sqrt i_inv_sqrt (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_start       (isqrt_start),
        .i_var_eps     (var_eps),
        .o_norm_factor (norm_factor),
        .o_done        (isqrt_done)
    );

    ln_norm_pipe i_norm (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_clear       (norm_clear),
        .i_rd          (norm_rd),
        .i_rd_idx      (rd_idx),
        .i_x           (i_x),
        .i_gamma       (i_gamma),
        .i_beta        (i_beta),
        .i_mean        (mean),
        .i_norm_factor (norm_factor),
        .o_y           (o_y)
    );

endmodule

`default_nettype wire

// ==== sim/tb_layer_norm.sv ====
// Self-checking testbench for the Q8.8 layer norm; one run at a time, inputs held from start to done
`default_nettype none

module tb_layer_norm;

    localparam int     N            = ln_pkg::FEATURE_DIM;
    localparam int     HALF_PERIOD  = 20;
    localparam int     DRIVE_DELAY  = 2;
    localparam int     RESET_CYCLES = 8;
    localparam int     RUN_TIMEOUT  = 500;    // Cycle limit far above one run
    localparam int     IDLE_CYCLES  = 20;
    localparam int     ONE_SHIFT    = 2 * ln_pkg::NF_FRAC + 2 * ln_pkg::FRAC_BITS;
    localparam longint NF_MAX       = (longint'(1) << (ln_pkg::NF_W - 1)) - 1;

    logic                              clk;
    logic                              rst_n;
    logic                              start;
    logic signed [ln_pkg::DATA_W-1:0]  x     [N];
    logic signed [ln_pkg::PARAM_W-1:0] gamma [N];
    logic signed [ln_pkg::PARAM_W-1:0] beta  [N];
    logic signed [ln_pkg::DATA_W-1:0]  y     [N];
    logic                              busy;
    logic                              done;

    logic signed [ln_pkg::DATA_W-1:0]  exp_y [N];
    string                             test_name;
    int                                done_seen    = 0;
    logic                              done_prev    = 1'b0;
    int                                mismatch_cnt = 0;
    int                                protocol_cnt = 0;
    int                                timeout_cnt  = 0;

    layer_norm_unit i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_start (start),
        .i_x     (x),
        .i_gamma (gamma),
        .i_beta  (beta),
        .o_y     (y),
        .o_busy  (busy),
        .o_done  (done)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Tests r*r*v against one in Q48 in a word wide enough for any 17-bit r
    function automatic bit root_fits(longint r, longint v);
        logic [127:0] prod;
        prod = 128'(r) * 128'(r) * 128'(v);
        return prod <= (128'(1) << ONE_SHIFT);
    endfunction

    function automatic longint inv_sqrt_ref(longint v);
        longint r;
        real    est;
        if (v <= 0) return NF_MAX;
        est = real'(longint'(1) << (ln_pkg::NF_FRAC + ln_pkg::FRAC_BITS)) / $sqrt(real'(v));
        r = (est >= real'(NF_MAX)) ? NF_MAX : longint'(est);
        while (r > 0 && !root_fits(r, v)) r--;              // Float estimate may be off by one
        while (r < NF_MAX && root_fits(r + 1, v)) r++;
        return r;
    endfunction

    // Expected outputs for the current x, gamma and beta
    function automatic void compute_expected();
        longint sum;
        longint sum_sq;
        longint mean;
        longint var_eps;
        longint nf;
        longint scaled;
        longint y_full;
        sum    = 0;
        sum_sq = 0;
        for (int i = 0; i < N; i++) begin
            sum    += longint'(x[i]);
            sum_sq += longint'(x[i]) * longint'(x[i]);
        end
        mean    = (sum * ln_pkg::RECIP_N) >>> ln_pkg::RECIP_SHIFT;
        var_eps = ((sum_sq * ln_pkg::RECIP_N) >>> ln_pkg::RECIP_SHIFT) - mean * mean;
        var_eps = var_eps + ln_pkg::EPSILON;
        nf      = inv_sqrt_ref(var_eps);
        for (int i = 0; i < N; i++) begin
            scaled   = (longint'(x[i]) - mean) * nf * longint'(gamma[i]);
            y_full   = (scaled + (longint'(beta[i]) <<< ln_pkg::OUT_SHIFT)) >>> ln_pkg::OUT_SHIFT;
            exp_y[i] = y_full[ln_pkg::DATA_W-1:0];         // Wraps like the hardware word
        end
    endfunction

    function automatic int rand_span(int half);
        return int'($urandom_range(2 * half - 1)) - half;
    endfunction

    function automatic void load_random(int x_half, int g_half, int b_half);
        for (int i = 0; i < N; i++) begin
            x[i]     = ln_pkg::DATA_W'(rand_span(x_half));
            gamma[i] = ln_pkg::PARAM_W'(rand_span(g_half));
            beta[i]  = ln_pkg::PARAM_W'(rand_span(b_half));
        end
    endfunction

    function automatic void compare_outputs(string name);
        for (int i = 0; i < N; i++) begin
            assert (y[i] === exp_y[i]) else begin
                $display("mismatch %s y[%0d]: expected %0d, actual %0d", name, i, exp_y[i], y[i]);
                mismatch_cnt++;
            end
        end
    endfunction

    task automatic wait_drive_slot();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // Starts one run on the current inputs and waits until the compare process has seen done
    task automatic run_vector(input string name, input bit hold_start);
        int seen_before;
        int waited;
        compute_expected();
        test_name   = name;
        seen_before = done_seen;
        start       = 1'b1;
        wait_drive_slot();
        if (!hold_start) start = 1'b0;
        assert (busy) else begin
            $display("o_busy stayed low in the cycle after the start edge of run %s", name);
            protocol_cnt++;
        end
        waited = 0;
        while (done_seen == seen_before && waited < RUN_TIMEOUT) begin
            wait_drive_slot();
            waited++;
        end
        assert (done_seen != seen_before) else begin
            $display("timeout: run %s gave no done pulse within %0d cycles", name, RUN_TIMEOUT);
            timeout_cnt++;
        end
    endtask

    // Compares at the falling edge where outputs are stable
    always @(negedge clk) begin : compare
        if (rst_n && done) begin
            assert (!busy) else begin
                $display("o_busy was high in the o_done cycle of run %s", test_name);
                protocol_cnt++;
            end
            assert (!done_prev) else begin
                $display("o_done stayed high for more than one cycle in run %s", test_name);
                protocol_cnt++;
            end
            compare_outputs(test_name);
            done_seen++;
        end
        done_prev = done;
    end

    initial begin : stimulus
        int seen_before;
        void'($urandom(21305));
        rst_n = 1'b0;
        start = 1'b0;
        for (int i = 0; i < N; i++) begin
            x[i]     = '0;
            gamma[i] = '0;
            beta[i]  = '0;
            exp_y[i] = '0;
        end
        test_name = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        @(negedge clk);
        assert (!busy && !done) else begin
            $display("o_busy or o_done was high after reset");
            protocol_cnt++;
        end
        compare_outputs("reset");                          // Expected all zero here
        wait_drive_slot();

        load_random(2048, 1, 1);
        for (int i = 0; i < N; i++) begin
            gamma[i] = ln_pkg::PARAM_W'(1 << ln_pkg::FRAC_BITS);
            beta[i]  = '0;
        end
        run_vector("identity", 1'b0);

        for (int t = 0; t < 3; t++) begin
            load_random(2048, 512, 1024);                  // x in +-8, gamma +-2, beta +-4
            run_vector("random", 1'b0);
        end

        load_random(2048, 512, 1024);
        for (int i = 1; i < N; i++) x[i] = x[0];
        run_vector("constant", 1'b0);

        // Held i_start must not start a second run after done
        load_random(2048, 512, 1024);
        run_vector("hold_start", 1'b1);
        seen_before = done_seen;
        for (int c = 0; c < IDLE_CYCLES; c++) begin
            @(negedge clk);
            assert (!busy) else begin
                $display("held i_start started a second run");
                protocol_cnt++;
            end
        end
        compare_outputs("held_output");
        wait_drive_slot();
        assert (done_seen == seen_before) else begin
            $display("o_done pulsed again while i_start was held");
            protocol_cnt++;
        end
        start = 1'b0;
        wait_drive_slot();

        load_random(2048, 512, 1024);
        run_vector("second_run", 1'b0);

        wait_drive_slot();
        $display("Error counts: mismatches %0d, protocol %0d, timeouts %0d",
                 mismatch_cnt, protocol_cnt, timeout_cnt);
        if (mismatch_cnt + protocol_cnt + timeout_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
hw/ln_pkg.sv
hw/ln_control.sv
hw/ln_stats_accum.sv
hw/ln_mean_var.sv
hw/ln_inv_sqrt.sv
hw/ln_norm_pipe.sv
hw/layer_norm_unit.sv
sim/tb_layer_norm.sv

// ==== Makefile ====
# Verilator build and run of the layer norm testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_layer_norm
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Verification passed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Pass line not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
